//--- source/radio_params.svh
/*
 * sample and settings bus widths
 * daughterboard settings register map
 * fixed-point constants of the sample scale factor
 */
`ifndef RADIO_PARAMS_SVH
`define RADIO_PARAMS_SVH

`default_nettype none

// ----------------------------------------------------------
// widths
`define RADIO_SAMPLE_W   16          // one I or Q sample
`define SET_ADDR_W       8
`define SET_DATA_W       32

// ----------------------------------------------------------
// daughterboard registers on the settings bus
`define SR_DB_BASE       8'd160
`define SR_MISC_OUT      8'd0        // word driven to the misc pins
`define SR_RUN           8'd1        // bit 1 rx, bit 0 tx
`define SR_DC_OFFSET     8'd2        // I offset high half, Q low half
`define SR_SCALE         8'd3        // signed, low 16 bits used

// scale factor is Q1.14
`define SCALE_FRAC_BITS  14
`define SCALE_UNITY      16'sd16384

`default_nettype wire

`endif

//--- source/radio_pkg.sv
/*
 * sample types of the radio loop
 * I/Q pair struct and the raw/I-Q word union
 */
`include "radio_params.svh"

`default_nettype none

package radio_pkg;

   // one signed I or Q sample
   typedef logic signed [`RADIO_SAMPLE_W-1:0] sample_t;

   // I in the upper half, Q in the lower half, as on the radio pins
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_sample_t;

   // a bus word seen either as 32 raw bits or as an I/Q pair
   typedef union packed {
      logic [2*`RADIO_SAMPLE_W-1:0] raw;
      iq_sample_t                   iq;
   } iq_word_u;

endpackage

`default_nettype wire

//--- source/radio_settings_regs.sv
/*
 * settings bus decoder for the daughterboard registers
 * misc output word, run flags, DC offset and scale factor
 */
`timescale 1ns/1ps
`include "radio_params.svh"

`default_nettype none

module radio_settings_regs (
   input  logic                   radio_clk,
   input  logic                   i_reset,
   input  logic                   i_set_stb,
   input  logic [`SET_ADDR_W-1:0] i_set_addr,
   input  logic [`SET_DATA_W-1:0] i_set_data,
   output logic [31:0]            o_misc_out,
   output logic                   o_run_rx,
   output logic                   o_run_tx,
   output logic                   o_rf_run,
   output radio_pkg::iq_word_u    o_dc_offset,
   output radio_pkg::sample_t     o_scale
);

   import radio_pkg::*;

   // ----------------------------------------------------------
   // address decode

   localparam logic [`SET_ADDR_W-1:0] addr_misc  = `SR_DB_BASE + `SR_MISC_OUT;
   localparam logic [`SET_ADDR_W-1:0] addr_run   = `SR_DB_BASE + `SR_RUN;
   localparam logic [`SET_ADDR_W-1:0] addr_dc    = `SR_DB_BASE + `SR_DC_OFFSET;
   localparam logic [`SET_ADDR_W-1:0] addr_scale = `SR_DB_BASE + `SR_SCALE;

   logic wr_misc;
   logic wr_run;
   logic wr_dc;
   logic wr_scale;

   // no acknowledge, a strobe is a write
   assign wr_misc  = i_set_stb && (i_set_addr == addr_misc);
   assign wr_run   = i_set_stb && (i_set_addr == addr_run);
   assign wr_dc    = i_set_stb && (i_set_addr == addr_dc);
   assign wr_scale = i_set_stb && (i_set_addr == addr_scale);

   // ----------------------------------------------------------
   // control registers

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_misc_out  <= '0;
         o_run_rx    <= 1'b0;
         o_run_tx    <= 1'b0;
         o_rf_run    <= 1'b0;
         o_dc_offset <= '0;
         o_scale     <= `SCALE_UNITY;    // pass samples through unchanged
      end else begin
         if (wr_misc) begin
            o_misc_out <= i_set_data;
         end
         if (wr_run) begin
            o_run_rx <= i_set_data[1];
            o_run_tx <= i_set_data[0];
            // loop enable, same edge as the flags themselves
            o_rf_run <= i_set_data[1] | i_set_data[0];
         end
         if (wr_dc) begin
            o_dc_offset.raw <= i_set_data;   // I high, Q low
         end
         if (wr_scale) begin
            o_scale <= sample_t'(i_set_data[`RADIO_SAMPLE_W-1:0]);
         end
      end
   end

endmodule

`default_nettype wire

//--- source/fe_dc_offset.sv
/*
 * front-end DC offset removal
 * subtracts the I and Q offsets with saturation, gated by run
 */
`timescale 1ns/1ps
`include "radio_params.svh"

`default_nettype none

module fe_dc_offset (
   input  logic                radio_clk,
   input  logic                i_reset,
   input  logic                i_rx_stb,
   input  radio_pkg::iq_word_u i_rx_data,
   input  logic                i_rf_run,
   input  radio_pkg::iq_word_u i_dc_offset,
   output logic                o_dc_stb,
   output radio_pkg::iq_word_u o_dc_data
);

   import radio_pkg::*;

   localparam sample_t s_max = {1'b0, {(`RADIO_SAMPLE_W-1){1'b1}}};
   localparam sample_t s_min = {1'b1, {(`RADIO_SAMPLE_W-1){1'b0}}};

   // difference is one bit wider, clip back to 16
   function automatic sample_t sat_sub(input sample_t a, input sample_t b);
      logic signed [`RADIO_SAMPLE_W:0] d;
      d = a - b;
      if (d[`RADIO_SAMPLE_W] != d[`RADIO_SAMPLE_W-1]) begin
         return d[`RADIO_SAMPLE_W] ? s_min : s_max;
      end
      return d[`RADIO_SAMPLE_W-1:0];
   endfunction

   logic     accept;
   iq_word_u diff;

   assign accept = i_rx_stb & i_rf_run;     // dropped while both run flags clear

   always_comb begin
      diff.iq.i = sat_sub(i_rx_data.iq.i, i_dc_offset.iq.i);
      diff.iq.q = sat_sub(i_rx_data.iq.q, i_dc_offset.iq.q);
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_dc_stb <= 1'b0;
      end else begin
         o_dc_stb <= accept;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (accept) begin
         o_dc_data <= diff;
      end
   end

endmodule

`default_nettype wire

//--- source/iq_scaler.sv
/*
 * I/Q scale multiply, two pipeline stages
 * stage one full product, stage two shift and saturate
 */
`timescale 1ns/1ps
`include "radio_params.svh"

`default_nettype none

module iq_scaler (
   input  logic                radio_clk,
   input  logic                i_reset,
   input  logic                i_dc_stb,
   input  radio_pkg::iq_word_u i_dc_data,
   input  radio_pkg::sample_t  i_scale,
   output logic                o_scl_stb,
   output radio_pkg::iq_word_u o_scl_data
);

   import radio_pkg::*;

   localparam int prod_w = 2 * `RADIO_SAMPLE_W;

   localparam sample_t s_max = {1'b0, {(`RADIO_SAMPLE_W-1){1'b1}}};
   localparam sample_t s_min = {1'b1, {(`RADIO_SAMPLE_W-1){1'b0}}};

   // drop the fraction (floor), then clip to the sample range
   function automatic sample_t shift_sat(input logic signed [prod_w-1:0] p);
      logic signed [prod_w-1:0] t;
      t = p >>> `SCALE_FRAC_BITS;
      if (t > s_max) begin
         return s_max;
      end else if (t < s_min) begin
         return s_min;
      end
      return t[`RADIO_SAMPLE_W-1:0];
   endfunction

   logic                     stb_s1;
   logic signed [prod_w-1:0] prod_i;
   logic signed [prod_w-1:0] prod_q;

   // ----------------------------------------------------------
   // strobe follows the data, one sample per cycle allowed

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         stb_s1    <= 1'b0;
         o_scl_stb <= 1'b0;
      end else begin
         stb_s1    <= i_dc_stb;
         o_scl_stb <= stb_s1;
      end
   end

   // ----------------------------------------------------------
   // stage one, full products

   always_ff @(posedge radio_clk) begin
      if (i_dc_stb) begin
         prod_i <= i_dc_data.iq.i * i_scale;   // 16x16 signed fits in 32
         prod_q <= i_dc_data.iq.q * i_scale;
      end
   end

   // stage two
   always_ff @(posedge radio_clk) begin
      if (stb_s1) begin
         o_scl_data.iq.i <= shift_sat(prod_i);
         o_scl_data.iq.q <= shift_sat(prod_q);
      end
   end

endmodule

`default_nettype wire

//--- source/radio_output.sv
/*
 * output registers toward the radio pins
 * transmit sample and strobe, LEDs, misc word
 */
`timescale 1ns/1ps

`default_nettype none

module radio_output (
   input  logic                radio_clk,
   input  logic                i_reset,
   input  logic                i_scl_stb,
   input  radio_pkg::iq_word_u i_scl_data,
   input  logic                i_run_rx,
   input  logic                i_run_tx,
   input  logic [31:0]         i_misc_out,
   output logic                o_tx_stb,
   output logic [31:0]         o_tx_data,
   output logic [1:0]          o_radio_led,
   output logic [31:0]         o_misc_out
);

   // ----------------------------------------------------------
   // transmit sample, held between strobes

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_tx_stb  <= 1'b0;
         o_tx_data <= '0;
      end else begin
         o_tx_stb <= i_scl_stb;
         if (i_scl_stb) begin
            o_tx_data <= i_scl_data.raw;
         end
      end
   end

   // ----------------------------------------------------------
   // status and misc pins

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_radio_led <= 2'b00;
         o_misc_out  <= '0;
      end else begin
         o_radio_led <= {i_run_rx, i_run_tx};   // bit 1 rx, bit 0 tx
         o_misc_out  <= i_misc_out;
      end
   end

endmodule

`default_nettype wire

//--- source/radio_core.sv
/*
 * radio clock core top level
 * settings registers, DC offset, scaler and output registers
 */
`timescale 1ns/1ps
`include "radio_params.svh"

`default_nettype none

module radio_core (
   input  logic                           radio_clk,
   input  logic                           i_reset,
   // settings bus
   input  logic                           i_set_stb,
   input  logic [`SET_ADDR_W-1:0]         i_set_addr,
   input  logic [`SET_DATA_W-1:0]         i_set_data,
   // sample stream
   input  logic                           i_rx_stb,
   input  logic [2*`RADIO_SAMPLE_W-1:0]   i_rx_data,
   output logic                           o_tx_stb,
   output logic [2*`RADIO_SAMPLE_W-1:0]   o_tx_data,
   // pins
   output logic [1:0]                     o_radio_led,
   output logic [31:0]                    o_misc_out
);

   import radio_pkg::*;

   logic [31:0] misc_reg;
   logic        run_rx;
   logic        run_tx;
   logic        rf_run;
   iq_word_u    dc_offset;
   sample_t     scale;

   logic        dc_stb;
   iq_word_u    dc_data;
   logic        scl_stb;
   iq_word_u    scl_data;

   // ----------------------------------------------------------
   // input side

   radio_settings_regs settings_regs_i (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .o_misc_out  (misc_reg),
      .o_run_rx    (run_rx),
      .o_run_tx    (run_tx),
      .o_rf_run    (rf_run),
      .o_dc_offset (dc_offset),
      .o_scale     (scale)
   );

   // ----------------------------------------------------------
   // sample processing, 3 cycles

   fe_dc_offset dc_offset_i (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_rx_stb    (i_rx_stb),
      .i_rx_data   (i_rx_data),
      .i_rf_run    (rf_run),
      .i_dc_offset (dc_offset),
      .o_dc_stb    (dc_stb),
      .o_dc_data   (dc_data)
   );

   iq_scaler scaler_i (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_dc_stb   (dc_stb),
      .i_dc_data  (dc_data),
      .i_scale    (scale),
      .o_scl_stb  (scl_stb),
      .o_scl_data (scl_data)
   );

   // output side, one more register
   radio_output output_i (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_scl_stb   (scl_stb),
      .i_scl_data  (scl_data),
      .i_run_rx    (run_rx),
      .i_run_tx    (run_tx),
      .i_misc_out  (misc_reg),
      .o_tx_stb    (o_tx_stb),
      .o_tx_data   (o_tx_data),
      .o_radio_led (o_radio_led),
      .o_misc_out  (o_misc_out)
   );

endmodule

`default_nettype wire

//--- testbench/radio_core_asserts.sv
/*
 * concurrent assertions on the radio core, bound to its top level
 * strobe latency, strobe quiet after reset, LEDs held in reset
 */
`timescale 1ns/1ps

`default_nettype none

module radio_core_asserts (
   input logic       radio_clk,
   input logic       i_reset,
   input logic       i_rx_stb,
   input logic       i_rf_run,
   input logic       i_tx_stb,
   input logic [1:0] i_radio_led
);

   logic [2:0] since_reset;     // counts cycles since release up to 4
   int         fail_count = 0;  // assertion failures so far

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         since_reset <= 3'd0;
      end else if (since_reset != 3'd4) begin
         since_reset <= since_reset + 3'd1;
      end
   end

   // ----------------------------------------------------------
   // pipeline is empty right after reset
   a_quiet_after_reset: assert property (@(posedge radio_clk)
      $fell(i_reset) |-> !i_tx_stb [*4])
      else begin
         $error("transmit strobe within 4 cycles of reset release");
         fail_count++;
      end

   // accepted strobes come out 4 cycles later and dropped ones never
   a_tx_latency: assert property (@(posedge radio_clk) disable iff (i_reset)
      (since_reset == 3'd4) |-> (i_tx_stb == $past(i_rx_stb && i_rf_run, 4)))
      else begin
         $error("transmit strobe does not follow accepted receive strobe");
         fail_count++;
      end

   a_led_in_reset: assert property (@(posedge radio_clk)
      (i_reset && $past(i_reset)) |-> (i_radio_led == 2'b00))
      else begin
         $error("radio LEDs lit during reset");
         fail_count++;
      end

endmodule

bind radio_core radio_core_asserts asserts_i (
   .radio_clk   (radio_clk),
   .i_reset     (i_reset),
   .i_rx_stb    (i_rx_stb),
   .i_rf_run    (rf_run),
   .i_tx_stb    (o_tx_stb),
   .i_radio_led (o_radio_led)
);

`default_nettype wire

//--- testbench/radio_core_tb.sv
/*
 * testbench for the radio core
 * clock and reset, random settings writes and sample stream
 * register mirror, expected-sample queue, checks and timeout
 */
`timescale 1ns/1ps
`include "radio_params.svh"

`default_nettype none

module radio_core_tb;

   localparam logic [7:0] addr_misc  = `SR_DB_BASE + `SR_MISC_OUT;
   localparam logic [7:0] addr_run   = `SR_DB_BASE + `SR_RUN;
   localparam logic [7:0] addr_dc    = `SR_DB_BASE + `SR_DC_OFFSET;
   localparam logic [7:0] addr_scale = `SR_DB_BASE + `SR_SCALE;
   localparam int         max_cycles = 6000;     // tests take about 2500

   logic        radio_clk;
   logic        i_reset;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;
   logic        i_rx_stb;
   logic [31:0] i_rx_data;
   logic        o_tx_stb;
   logic [31:0] o_tx_data;
   logic [1:0]  o_radio_led;
   logic [31:0] o_misc_out;

   integer      seed;
   int          cyc = 0;
   string       cur_test;

   // register mirror
   logic [31:0] m_misc = '0;
   logic        m_run_rx = 1'b0;
   logic        m_run_tx = 1'b0;
   logic [31:0] m_dc = '0;
   logic [15:0] m_scale = 16'd16384;

   logic [31:0] exp_data[$];    // expected transmit words in arrival order
   int          exp_due[$];     // cycle each one must appear in

   radio_core UUT (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .i_rx_stb    (i_rx_stb),
      .i_rx_data   (i_rx_data),
      .o_tx_stb    (o_tx_stb),
      .o_tx_data   (o_tx_data),
      .o_radio_led (o_radio_led),
      .o_misc_out  (o_misc_out)
   );

   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;
   end

   // ----------------------------------------------------------
   // reporting

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         report_failure($sformatf("MISMATCH %s: expected %h, actual %h",
                                  test, expected, actual));
      end
   endtask

   always @(posedge radio_clk) begin
      cyc <= cyc + 1;
      if (cyc >= max_cycles) begin
         report_failure($sformatf("timeout, run not finished after %0d cycles", max_cycles));
      end
   end

   always @(negedge radio_clk) begin
      if (UUT.asserts_i.fail_count != 0) begin
         report_failure("a bound assertion on the core failed");
      end
   end

   // ----------------------------------------------------------
   // reference model of one sample

   function automatic int clip16(input int v);
      if (v > 32767) return 32767;
      if (v < -32768) return -32768;
      return v;
   endfunction

   // division by 2**14 rounded toward minus infinity
   function automatic int floor_div(input int p);
      int q;
      q = p / 16384;
      if (p < 0 && (p % 16384) != 0) q = q - 1;
      return q;
   endfunction

   function automatic logic [31:0] expected_tx(input logic [31:0] rx,
                                               input logic [31:0] dc,
                                               input logic [15:0] scale);
      int yi;
      int yq;
      yi = clip16(floor_div(clip16($signed(rx[31:16]) - $signed(dc[31:16]))
                            * $signed(scale)));
      yq = clip16(floor_div(clip16($signed(rx[15:0]) - $signed(dc[15:0]))
                            * $signed(scale)));
      return {yi[15:0], yq[15:0]};
   endfunction

   // mostly random with the two extremes mixed in
   function automatic logic [15:0] pick_sample();
      logic [1:0] sel;
      sel = $random(seed);
      case (sel)
         2'd0:    return 16'h7fff;
         2'd1:    return 16'h8000;
         default: return $random(seed);
      endcase
   endfunction

   // ----------------------------------------------------------
   // driving tasks take one clock per call

   task automatic update_model(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         addr_misc:  m_misc = data;
         addr_run: begin
            m_run_rx = data[1];
            m_run_tx = data[0];
         end
         addr_dc:    m_dc = data;
         addr_scale: m_scale = data[15:0];
         default:    ;                      // not decoded
      endcase
   endtask

   task automatic drive(input logic set_stb, input logic [7:0] addr, input logic [31:0] data,
                        input logic rx_stb, input logic [31:0] rx_data);
      @(posedge radio_clk);
      // sample sees the settings from before this write
      if (rx_stb && (m_run_rx || m_run_tx)) begin
         exp_data.push_back(expected_tx(rx_data, m_dc, m_scale));
         exp_due.push_back(cyc + 5);
      end
      if (set_stb) update_model(addr, data);
      i_set_stb  <= set_stb;
      i_set_addr <= addr;
      i_set_data <= data;
      i_rx_stb   <= rx_stb;
      i_rx_data  <= rx_data;
   endtask

   task automatic idle();
      drive(1'b0, 8'd0, 32'd0, 1'b0, 32'd0);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      drive(1'b1, addr, data, 1'b0, 32'd0);
   endtask

   task automatic send(input logic [31:0] data);
      drive(1'b0, 8'd0, 32'd0, 1'b1, data);
   endtask

   task automatic drain();
      while (exp_data.size() > 0) idle();
      repeat (4) idle();
   endtask

   // register write reaches the pins 2 cycles later
   task automatic check_pins();
      idle();
      idle();
      @(negedge radio_clk);
      check_value(cur_test, m_misc, o_misc_out);
      check_value(cur_test, {30'd0, m_run_rx, m_run_tx}, {30'd0, o_radio_led});
   endtask

   // ----------------------------------------------------------
   // transmit monitor samples outputs at the falling edge

   always @(negedge radio_clk) begin : tx_monitor
      logic [31:0] want;
      int          due;
      if (!i_reset) begin
         if (o_tx_stb) begin
            if (exp_data.size() == 0) begin
               report_failure($sformatf("transmit strobe at cycle %0d with no sample in flight",
                                        cyc));
            end else begin
               want = exp_data.pop_front();
               due  = exp_due.pop_front();
               if (due != cyc) begin
                  report_failure($sformatf("transmit strobe at cycle %0d, expected at %0d",
                                           cyc, due));
               end else begin
                  check_value(cur_test, want, o_tx_data);
               end
            end
         end else if (exp_due.size() > 0 && exp_due[0] <= cyc) begin
            report_failure($sformatf("no transmit strobe at cycle %0d for an accepted sample",
                                     exp_due[0]));
         end
      end
   end

   // ----------------------------------------------------------
   // tests

   task automatic test_after_reset();
      cur_test = "after reset";
      @(negedge radio_clk);
      check_value(cur_test, 32'd0, {31'd0, o_tx_stb});
      check_value(cur_test, 32'd0, o_tx_data);
      check_value(cur_test, 32'd0, {30'd0, o_radio_led});
      check_value(cur_test, 32'd0, o_misc_out);
      repeat (16) send($random(seed));    // nothing accepted with run flags clear
      repeat (8) idle();
   endtask

   task automatic test_settings();
      logic [7:0] addr;
      cur_test = "settings decode";
      repeat (20) begin
         write_reg(addr_misc, $random(seed));
         check_pins();
      end
      repeat (20) begin
         addr = $random(seed);
         if (addr >= addr_misc && addr <= addr_scale) addr = addr ^ 8'h10;
         write_reg(addr, $random(seed));
         check_pins();
      end
   endtask

   task automatic test_passthrough();
      cur_test = "unity pass-through";
      write_reg(addr_run, 32'd3);
      repeat (200) send($random(seed));
      drain();
   endtask

   task automatic test_offset_scale();
      logic [1:0] sel;
      cur_test = "offset and scale";
      repeat (8) begin
         write_reg(addr_dc, {pick_sample(), pick_sample()});
         sel = $random(seed);
         // full-scale factors drive the products past both limits
         if (sel == 2'd0) write_reg(addr_scale, 32'h7fff);
         else if (sel == 2'd1) write_reg(addr_scale, 32'h8000);
         else write_reg(addr_scale, $random(seed));
         repeat (120) begin
            if ($random(seed) & 1) send({pick_sample(), pick_sample()});
            else idle();
         end
         drain();
      end
   endtask

   task automatic test_run_flags();
      cur_test = "run flags";
      for (int r = 0; r < 4; r++) begin
         write_reg(addr_run, r);
         check_pins();
         repeat (10) send($random(seed));
         drain();
      end
      write_reg(addr_run, 32'd3);
      repeat (30) send($random(seed));
      drive(1'b1, addr_run, 32'd0, 1'b1, $random(seed));   // last one still accepted
      repeat (30) send($random(seed));
      drain();
      check_pins();
   endtask

   initial begin : main
      seed       = 32'hbe56fed5;
      cur_test   = "reset";
      i_reset    = 1'b1;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_rx_stb   = 1'b0;
      i_rx_data  = '0;
      repeat (2) @(posedge radio_clk);
      i_reset <= 1'b0;

      test_after_reset();
      test_settings();
      test_passthrough();
      test_offset_scale();
      test_run_flags();

      if (UUT.asserts_i.fail_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/radio_pkg.sv
source/radio_settings_regs.sv
source/fe_dc_offset.sv
source/iq_scaler.sv
source/radio_output.sv
source/radio_core.sv
testbench/radio_core_asserts.sv
testbench/radio_core_tb.sv
